// ==== bus_pkg.sv ====
/* AXI4-Lite response codes and register word index */

package bus_pkg;

    // Only the two codes the slave ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    // Word index, taken from address bits 5:2
    typedef logic [3:0] reg_idx_t;

endpackage

// ==== cen_channel.sv ====
/* One clock-enable channel, fractional accumulator or modulo phase counter */

module cen_channel
    import cen_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     clr,       // Latch cfg, restart
    input  logic     run,       // Window running
    input  logic     ena,       // Mask bit
    input  cen_cfg_u cfg,
    output logic     cen        // Registered one-cycle pulse
);

cen_cfg_u    cfg_q;             // Held for the whole window
logic [15:0] acc;               // Fractional accumulator
logic [15:0] k;                 // Modulo counter
logic [15:0] eff_step;
logic [16:0] acc_nx;
logic        acc_bad, frac_hit, int_hit;
logic [15:0] k_nx;

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
        cfg_q <= '0;
    else if (clr)
        cfg_q <= cfg;
end

////////////////////
// Next-state terms

always_comb begin
    // Step never above limit
    eff_step = ({1'b0, cfg_q.frac.step} > cfg_q.frac.limit) ? cfg_q.frac.limit
                                                            : {1'b0, cfg_q.frac.step};
    acc_nx   = {1'b0, acc} + {1'b0, eff_step};
    // Accumulator can't legally reach limit, also true for limit 0
    acc_bad  = acc >= cfg_q.frac.limit;
    frac_hit = !acc_bad && acc_nx >= {1'b0, cfg_q.frac.limit};
    // Phase past period never matches
    int_hit  = cfg_q.integ.period != 16'd0 && k == {8'd0, cfg_q.integ.phase};
    k_nx     = (k + 16'd1 >= cfg_q.integ.period) ? 16'd0 : k + 16'd1;
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        acc <= '0;
        k   <= '0;
        cen <= 1'b0;
    end else begin
        cen <= 1'b0;
        if (clr) begin
            acc <= '0;
            k   <= '0;
        end else if (run) begin
            if (cfg_q.frac.mode == MODE_INT) begin
                k   <= k_nx;
                cen <= ena && int_hit;
            end else if (acc_bad) begin
                acc <= '0;                      // Restart
            end else if (frac_hit) begin
                acc <= acc_nx[15:0] - cfg_q.frac.limit;
                cen <= ena;
            end else begin
                acc <= acc_nx[15:0];
            end
        end
    end
end

endmodule

// ==== cen_defs.svh ====
/* Channel count, bus widths, counter and window widths, register map offsets */

`ifndef CEN_DEFS_SVH
`define CEN_DEFS_SVH

////////////////////
// Sizes

`define CEN_NCH     4           // Clock-enable channels
`define CEN_CNT_W   16          // Pulse counter width
`define CEN_WIN_W   16          // Window length width

`define CEN_ADDR_W  8           // AXI4-Lite address
`define CEN_DATA_W  32          // AXI4-Lite data

////////////////////
// Register map, byte offsets

`define REG_CTRL    8'h00       // Wr bit0 start, rd {done, busy}
`define REG_WINDOW  8'h04       // Window length in clk cycles
`define REG_ENABLE  8'h08       // Channel mask
`define REG_CFG0    8'h10       // CFG[i] at 0x10 + 4*i
`define REG_CNT0    8'h20       // COUNT[i] at 0x20 + 4*i, read only

`endif

// ==== cen_pkg.sv ====
/* Channel mode and the configuration word with its fractional and integer views */

package cen_pkg;

    typedef enum logic {
        MODE_FRAC = 1'b0,   // Accumulate step, subtract limit
        MODE_INT  = 1'b1    // Modulo counter with phase
    } cen_mode_t;

    ////////////////////
    // Fractional view

    typedef struct packed {
        cen_mode_t   mode;      // Bit 31 in both views
        logic [14:0] step;      // Clamped to limit
        logic [15:0] limit;     // 0 gives no pulses
    } cen_frac_t;

    ////////////////////
    // Integer view

    typedef struct packed {
        cen_mode_t   mode;
        logic [6:0]  rsvd;
        logic [7:0]  phase;     // Pulse when counter equals phase
        logic [15:0] period;    // 0 gives no pulses
    } cen_int_t;

    // Mode bit sits at the same place, so it picks the view
    typedef union packed {
        cen_frac_t frac;
        cen_int_t  integ;
    } cen_cfg_u;

endpackage

// ==== cen_props.sv ====
/* Bound assertions on AXI4-Lite response holding, clr/run exclusion and pulse timing */

module cen_props (
    input logic clk,
    input logic rst_n,
    input logic clr,
    input logic run,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic cen
);

timeunit 1ns;
timeprecision 1ps;

// Responses stay up until taken
a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

a_clr_run: assert property (@(posedge clk) disable iff (!rst_n) !(clr && run))
    else $error("clr and run high together");

// Registered pulse follows a run cycle
a_cen_run: assert property (@(posedge clk) disable iff (!rst_n) cen |-> $past(run))
    else $error("cen without a run cycle before it");

endmodule

bind cen_regs cen_props u_props (.clk, .rst_n, .clr, .run, .bvalid, .bready, .rvalid,
    .rready, .cen(1'b0));
bind cen_channel cen_props u_props (.clk, .rst_n, .clr, .run, .bvalid(1'b0), .bready(1'b1),
    .rvalid(1'b0), .rready(1'b1), .cen);

// ==== cen_regs.sv ====
/* AXI4-Lite slave with register file, window timer and start/clear sequencing */

`include "cen_defs.svh"

module cen_regs
    import bus_pkg::*, cen_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    // Write address and data
    input  logic [`CEN_ADDR_W-1:0]               awaddr,
    input  logic                                 awvalid,
    output logic                                 awready,
    input  logic [`CEN_DATA_W-1:0]               wdata,
    input  logic                                 wvalid,
    output logic                                 wready,
    output axi_resp_t                            bresp,
    output logic                                 bvalid,
    input  logic                                 bready,
    // Read
    input  logic [`CEN_ADDR_W-1:0]               araddr,
    input  logic                                 arvalid,
    output logic                                 arready,
    output logic [`CEN_DATA_W-1:0]               rdata,
    output axi_resp_t                            rresp,
    output logic                                 rvalid,
    input  logic                                 rready,
    // To channels and counters
    output logic                                 clr,
    output logic                                 run,
    output cen_cfg_u [`CEN_NCH-1:0]              cfg,
    output logic [`CEN_NCH-1:0]                  ena_mask,
    input  logic [`CEN_NCH-1:0][`CEN_CNT_W-1:0]  cnt
);

localparam reg_idx_t IDX_CTRL   = reg_idx_t'(`REG_CTRL >> 2);
localparam reg_idx_t IDX_WINDOW = reg_idx_t'(`REG_WINDOW >> 2);
localparam reg_idx_t IDX_ENABLE = reg_idx_t'(`REG_ENABLE >> 2);
localparam reg_idx_t IDX_CFG0   = reg_idx_t'(`REG_CFG0 >> 2);
localparam reg_idx_t IDX_CNT0   = reg_idx_t'(`REG_CNT0 >> 2);
localparam int       CH_W       = $clog2(`CEN_NCH);

logic                   wr_hs, rd_hs;
reg_idx_t               wr_idx, rd_idx;
logic                   wr_map, rd_map;     // Address bits outside 5:2 clear
logic                   wr_cfg, rd_cfg, rd_cnt, wr_ok;
logic [CH_W-1:0]        wr_ch, rd_cfg_ch, rd_cnt_ch;
logic                   start;
logic [`CEN_DATA_W-1:0] rd_data;
logic                   rd_ok;
logic [`CEN_WIN_W-1:0]  window_r;
logic [`CEN_WIN_W-1:0]  win_cnt;            // Run cycles left
logic [1:0]             drain;              // Wait for last count to land
logic                   busy, done;

////////////////////
// Address decode

assign wr_hs  = awready && awvalid && wvalid;   // wready mirrors awready
assign rd_hs  = arready && arvalid;
assign wr_idx = awaddr[5:2];
assign rd_idx = araddr[5:2];
assign wr_map = awaddr[`CEN_ADDR_W-1:6] == '0 && awaddr[1:0] == 2'd0;
assign rd_map = araddr[`CEN_ADDR_W-1:6] == '0 && araddr[1:0] == 2'd0;

assign wr_ch     = CH_W'(wr_idx - IDX_CFG0);
assign rd_cfg_ch = CH_W'(rd_idx - IDX_CFG0);
assign rd_cnt_ch = CH_W'(rd_idx - IDX_CNT0);
assign wr_cfg    = wr_map && wr_idx >= IDX_CFG0 && wr_idx < IDX_CFG0 + `CEN_NCH;
assign rd_cfg    = rd_map && rd_idx >= IDX_CFG0 && rd_idx < IDX_CFG0 + `CEN_NCH;
assign rd_cnt    = rd_map && rd_idx >= IDX_CNT0 && rd_idx < IDX_CNT0 + `CEN_NCH;

// COUNT is not writable, so it falls in with unmapped
assign wr_ok = wr_cfg || (wr_map && (wr_idx == IDX_CTRL || wr_idx == IDX_WINDOW ||
                                     wr_idx == IDX_ENABLE));
assign start = wr_hs && wr_map && wr_idx == IDX_CTRL && wdata[0] && !busy;

always_comb begin
    rd_data = '0;                               // Unmapped reads 0
    rd_ok   = 1'b1;
    if (rd_map && rd_idx == IDX_CTRL)   rd_data = `CEN_DATA_W'({done, busy});
    else if (rd_map && rd_idx == IDX_WINDOW) rd_data = `CEN_DATA_W'(window_r);
    else if (rd_map && rd_idx == IDX_ENABLE) rd_data = `CEN_DATA_W'(ena_mask);
    else if (rd_cfg) rd_data = cfg[rd_cfg_ch];
    else if (rd_cnt) rd_data = `CEN_DATA_W'(cnt[rd_cnt_ch]);
    else rd_ok = 1'b0;
end

////////////////////
// Handshakes

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        awready <= 1'b0;
        wready  <= 1'b0;
        bvalid  <= 1'b0;
        bresp   <= OKAY;
        arready <= 1'b0;
        rvalid  <= 1'b0;
        rresp   <= OKAY;
        rdata   <= '0;
    end else begin
        // Ready pulses for a single cycle
        awready <= !awready && awvalid && wvalid && !bvalid;
        wready  <= !awready && awvalid && wvalid && !bvalid;
        arready <= !arready && arvalid && !rvalid;
        if (wr_hs) begin
            bvalid <= 1'b1;
            bresp  <= wr_ok ? OKAY : SLVERR;
        end else if (bready) begin
            bvalid <= 1'b0;                     // Held until accepted
        end
        if (rd_hs) begin
            rvalid <= 1'b1;
            rresp  <= rd_ok ? OKAY : SLVERR;
            rdata  <= rd_data;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end
end

// Register file
always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        window_r <= '0;
        ena_mask <= '0;
        cfg      <= '0;
    end else if (wr_hs) begin
        if (wr_map && wr_idx == IDX_WINDOW) window_r <= wdata[`CEN_WIN_W-1:0];
        if (wr_map && wr_idx == IDX_ENABLE) ena_mask <= wdata[`CEN_NCH-1:0];
        if (wr_cfg) cfg[wr_ch] <= wdata;
    end
end

////////////////////
// Window sequencer

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        clr     <= 1'b0;
        run     <= 1'b0;
        win_cnt <= '0;
        drain   <= 2'd0;
        busy    <= 1'b0;
        done    <= 1'b0;
    end else begin
        clr <= start;                           // One cycle after the handshake
        if (start) begin
            busy    <= 1'b1;
            done    <= 1'b0;
            win_cnt <= window_r;
        end
        if (clr) begin
            run <= win_cnt != '0;
            if (win_cnt == '0) drain <= 2'd2;   // Empty window
        end else if (run) begin
            win_cnt <= win_cnt - 1'b1;
            if (win_cnt == 1) begin
                run   <= 1'b0;
                drain <= 2'd2;                  // Pulse stage then count stage
            end
        end else if (drain != 2'd0) begin
            drain <= drain - 2'd1;
            if (drain == 2'd1) begin
                busy <= 1'b0;
                done <= 1'b1;                   // Counts are final now
            end
        end
    end
end

endmodule

// ==== cen_tick_count.sv ====
/* Saturating pulse counters, one per channel */

`include "cen_defs.svh"

module cen_tick_count (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 clr,   // Window start
    input  logic [`CEN_NCH-1:0]                  cen,   // Channel pulses
    output logic [`CEN_NCH-1:0][`CEN_CNT_W-1:0]  cnt
);

////////////////////
// Counters

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        cnt <= '0;
    end else begin
        for (int i = 0; i < `CEN_NCH; i++) begin
            if (clr)
                cnt[i] <= '0;
            else if (cen[i] && cnt[i] != '1)   // Stick at all ones
                cnt[i] <= cnt[i] + 1'b1;
        end
    end
end

endmodule

// ==== cen_top.sv ====
/* Top level, register block, channel array and pulse counters */

`include "cen_defs.svh"

module cen_top
    import bus_pkg::*, cen_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CEN_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`CEN_DATA_W-1:0] wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output axi_resp_t              bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [`CEN_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [`CEN_DATA_W-1:0] rdata,
    output axi_resp_t              rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output logic [`CEN_NCH-1:0]    cen
);

logic                                clr, run;
cen_cfg_u [`CEN_NCH-1:0]             cfg;
logic [`CEN_NCH-1:0]                 ena_mask;
logic [`CEN_NCH-1:0][`CEN_CNT_W-1:0] cnt;

cen_regs u_regs (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .clr, .run, .cfg, .ena_mask, .cnt
);

// One divider per channel
for (genvar i = 0; i < `CEN_NCH; i++) begin : g_ch
    cen_channel u_ch (
        .clk, .rst_n, .clr, .run,
        .ena (ena_mask[i]),
        .cfg (cfg[i]),
        .cen (cen[i])
    );
end

cen_tick_count u_count (.clk, .rst_n, .clr, .cen, .cnt);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the clock-enable generator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_cen -f vlog.f

./obj_dir/Vtb_cen 2>&1 | tee sim.log

# Result comes from the log
grep -q '^TB PASSED$' sim.log

// ==== tb_cen.sv ====
/* Testbench for the clock-enable generator with AXI4-Lite tasks, xorshift stimulus,
   reference pulse-count model and checks */

`include "cen_defs.svh"

module tb_cen
    import bus_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int         TMO = 20;                        // Cycles per handshake wait
localparam logic [7:0] BAD_ADDR [3] = '{8'h0c, 8'h40, 8'h84};

logic                clk;
logic                rst_n;
logic [7:0]          awaddr, araddr;
logic [31:0]         wdata, rdata;
logic                awvalid, awready, wvalid, wready, bvalid, bready;
logic                arvalid, arready, rvalid, rready;
axi_resp_t           bresp, rresp;
logic [`CEN_NCH-1:0] cen;
logic [31:0]         seed = 32'h25f04c40;
logic [31:0]         cfg_m [`CEN_NCH];                  // Model copy of CFG[i]
logic [`CEN_NCH-1:0] ena_m;                             // Model copy of ENABLE
int                  cen_seen [`CEN_NCH];               // Running pulse totals on cen
int                  cen_base [`CEN_NCH];               // Totals at window start
int                  errors, checks, err_mark;

cen_top dut0 (.*);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

// Pulses on the cen port, sampled mid-cycle
always @(negedge clk) begin
    for (int i = 0; i < `CEN_NCH; i++)
        if (cen[i]) cen_seen[i]++;
end

////////////////////
// Stimulus and model

function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
endfunction

// Pulses expected over an n-cycle window
function automatic int expected_count(input logic [31:0] cfg, input logic ena, input int n);
    int step, limit, period, phase;
    if (!ena) return 0;
    if (cfg[31]) begin                                  // Integer view
        period = cfg[15:0];
        phase  = cfg[23:16];
        if (period == 0 || phase >= period || n <= phase) return 0;
        return (n - 1 - phase) / period + 1;
    end
    limit = cfg[15:0];
    step  = cfg[30:16];
    if (limit == 0) return 0;
    if (step > limit) step = limit;                     // Effective step
    return (n * step) / limit;
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("[ERROR] %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
    end
endtask

task automatic report_timeout(input string what);
    errors++;
    $display("Timeout, no %s within %0d cycles at %0t", what, TMO, $time);
endtask

////////////////////
// AXI4-Lite master

task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, input int hold,
                         output logic [1:0] resp);
    int t;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    for (t = 0; t < TMO && !awready; t++) begin
        @(posedge clk);
        #5;
    end
    if (!awready) report_timeout("awready");
    check("wready", wready, 1'b1);                      // Raised with awready
    @(posedge clk);                                     // Handshake edge
    #5;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    for (t = 0; t < TMO && !bvalid; t++) begin
        @(posedge clk);
        #5;
    end
    if (!bvalid) report_timeout("bvalid");
    resp = bresp;
    repeat (hold) begin                                 // Back-pressure
        @(posedge clk);
        #5;
        check("bvalid", bvalid, 1'b1);
        check("bresp", bresp, resp);
    end
    bready = 1'b1;
    @(posedge clk);
    #5;
    bready = 1'b0;
endtask

task automatic axi_read(input logic [7:0] addr, input int hold, output logic [31:0] data,
                        output logic [1:0] resp);
    int t;
    araddr  = addr;
    arvalid = 1'b1;
    for (t = 0; t < TMO && !arready; t++) begin
        @(posedge clk);
        #5;
    end
    if (!arready) report_timeout("arready");
    @(posedge clk);
    #5;
    arvalid = 1'b0;
    for (t = 0; t < TMO && !rvalid; t++) begin
        @(posedge clk);
        #5;
    end
    if (!rvalid) report_timeout("rvalid");
    data = rdata;
    resp = rresp;
    repeat (hold) begin
        @(posedge clk);
        #5;
        check("rvalid", rvalid, 1'b1);
        check("rdata", rdata, data);                    // Must not move while held
        check("rresp", rresp, resp);
    end
    rready = 1'b1;
    @(posedge clk);
    #5;
    rready = 1'b0;
endtask

task automatic write_ok(input logic [7:0] addr, input logic [31:0] data, input int hold);
    logic [1:0] resp;
    axi_write(addr, data, hold, resp);
    check("bresp", resp, OKAY);
endtask

task automatic read_expect(input string name, input logic [7:0] addr, input logic [31:0] exp,
                           input int hold);
    logic [31:0] d;
    logic [1:0]  resp;
    axi_read(addr, hold, d, resp);
    check(name, d, exp);
    check("rresp", resp, OKAY);
endtask

////////////////////
// Test steps

task automatic load_config(input int hold);
    for (int i = 0; i < `CEN_NCH; i++)
        write_ok(8'(`REG_CFG0 + 4 * i), cfg_m[i], hold);
    write_ok(`REG_ENABLE, 32'(ena_m), hold);
endtask

task automatic verify_config(input int hold);
    read_expect("enable", `REG_ENABLE, 32'(ena_m), hold);
    for (int i = 0; i < `CEN_NCH; i++)
        read_expect($sformatf("cfg%0d", i), 8'(`REG_CFG0 + 4 * i), cfg_m[i], hold);
endtask

task automatic run_window(input int n);
    logic [31:0] d;
    logic [1:0]  resp;
    int          t;
    write_ok(`REG_WINDOW, n, 0);
    for (int i = 0; i < `CEN_NCH; i++)
        cen_base[i] = cen_seen[i];
    write_ok(`REG_CTRL, 32'h1, 0);                      // Start
    d = '0;
    for (t = 0; t < 100 && !d[1]; t++)                  // Poll for done
        axi_read(`REG_CTRL, 0, d, resp);
    if (!d[1]) report_timeout("window done");
    check("ctrl", d, 32'h2);                            // done set, busy clear
endtask

task automatic check_counts(input int n, input int hold);
    int exp_cnt;
    for (int i = 0; i < `CEN_NCH; i++) begin
        exp_cnt = expected_count(cfg_m[i], ena_m[i], n);
        read_expect($sformatf("count%0d", i), 8'(`REG_CNT0 + 4 * i), exp_cnt, hold);
        check($sformatf("cen[%0d] pulses", i), cen_seen[i] - cen_base[i], exp_cnt);
    end
endtask

task automatic random_frac();
    logic [14:0] step;
    logic [15:0] limit;
    for (int i = 0; i < `CEN_NCH; i++) begin
        step  = 15'(next_rand()) & 15'h3f;
        limit = 16'(next_rand()) & 16'h1f;
        if (i == 0) limit = 16'd0;                      // No pulses
        if (i == 1) step = 15'(limit) + 15'd5;          // Clamped
        cfg_m[i] = {1'b0, step, limit};
    end
endtask

task automatic random_int();
    logic [15:0] period;
    logic [7:0]  phase;
    for (int i = 0; i < `CEN_NCH; i++) begin
        period = 16'(next_rand()) & 16'hf;
        phase  = 8'(next_rand()) & 8'hf;
        if (i == 0) begin
            period = 16'd0;
            phase  = 8'd0;                              // Counter sits on phase
        end
        if (i == 1) phase = 8'(period) + 8'd2;          // Phase past period
        cfg_m[i] = {1'b1, 7'd0, phase, period};
    end
endtask

task automatic end_test(input string name);
    $display("test %s: %0d errors", name, errors - err_mark);
    err_mark = errors;
endtask

initial begin
    int          n;
    logic [31:0] d;
    logic [1:0]  resp;
    errors   = 0;
    checks   = 0;
    err_mark = 0;
    rst_n    = 1'b0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    repeat (2) @(posedge clk);
    #5;
    rst_n = 1'b1;

    n = int'(next_rand() & 32'hffff);
    write_ok(`REG_WINDOW, n, 0);
    ena_m = 4'(next_rand());
    for (int i = 0; i < `CEN_NCH; i++)
        cfg_m[i] = next_rand();
    load_config(0);
    read_expect("window", `REG_WINDOW, n, 0);
    verify_config(0);
    end_test("readback");

    ena_m = '1;
    repeat (3) begin
        random_frac();
        load_config(0);
        n = 1 + int'(next_rand() % 120);
        run_window(n);
        check_counts(n, 0);
    end
    end_test("fractional");

    repeat (3) begin
        random_int();
        load_config(0);
        n = 1 + int'(next_rand() % 120);
        run_window(n);
        check_counts(n, 0);
    end
    end_test("integer");

    // Every channel would pulse each cycle or so if enabled
    for (int i = 0; i < `CEN_NCH; i++)
        cfg_m[i] = {1'b1, 7'd0, 8'd0, 16'(i + 1)};
    ena_m = 4'b0101;
    load_config(0);
    n = 40;
    run_window(n);
    check_counts(n, 0);
    end_test("mask");

    axi_write(`REG_CNT0, 32'h1234, 0, resp);
    check("bresp", resp, SLVERR);                       // COUNT is read only
    for (int i = 0; i < 3; i++) begin
        axi_write(BAD_ADDR[i], next_rand(), 0, resp);
        check("bresp", resp, SLVERR);
        axi_read(BAD_ADDR[i], 0, d, resp);
        check("rresp", resp, SLVERR);
        check("rdata", d, 32'h0);
    end
    read_expect("window", `REG_WINDOW, n, 0);
    verify_config(0);
    check_counts(n, 0);
    end_test("errors");

    random_frac();
    ena_m = '1;
    load_config(4);
    n = 1 + int'(next_rand() % 120);
    run_window(n);
    check_counts(n, 3);
    verify_config(3);
    end_test("backpressure");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
        $display("TB PASSED");
    else
        $display("TB FAILED");
    $finish;
end

endmodule

// ==== vlog.f ====
+incdir+.
bus_pkg.sv
cen_pkg.sv
cen_regs.sv
cen_channel.sv
cen_tick_count.sv
cen_top.sv
cen_props.sv
tb_cen.sv
